// ==== hw/spi_mem_pkg.sv ====
package spi_mem_pkg;

	//----------------------------------------------------------------------
	// widths and sizes
	//----------------------------------------------------------------------
	localparam int addr_w = 7;
	localparam int data_w = 8;
	localparam int mem_depth = 128; // one entry per address
	localparam int cond_wait = 3; // stable clk cycles before a level is taken

	typedef logic [addr_w-1:0] addr_t; // memory address
	typedef logic [data_w-1:0] data_t; // one byte, memory or shifter

	// command byte as it lands in the shifter, msb first
	typedef struct packed {
		addr_t addr; // bits 7..1
		logic  rd;   // bit 0, 1 means read
	} spi_cmd_t;

	//----------------------------------------------------------------------
	// transaction fsm
	//----------------------------------------------------------------------
	typedef enum logic [2:0] {
		st_get,
		st_got,
		st_read0,
		st_read1,
		st_read2,
		st_write0,
		st_write1,
		st_done
	} spi_state_t;

	typedef struct packed {
		logic addr_we;   // latch address from shifter
		logic dm_we;     // write shifter into memory
		logic sr_we;     // parallel load shifter from memory
		logic miso_buff; // miso valid, goes out as miso_en
	} spi_strobes_t;

endpackage

// ==== hw/input_conditioner.sv ====
`timescale 1ns/10ps

module input_conditioner (
	input  logic clk,
	input  logic reset,
	input  logic noisy,       // raw pin, async to clk
	output logic conditioned, // filtered level
	output logic pos_edge,    // one cycle on filtered rise
	output logic neg_edge     // one cycle on filtered fall
);
	import spi_mem_pkg::*;

	localparam int cnt_w = $clog2(cond_wait + 1);

	logic sync0;
	logic sync1;
	logic [cnt_w-1:0] cnt; // cycles the new level has held

	// two flop synchronizer
	always_ff @(posedge clk) begin
		if (reset) begin
			sync0 <= 1'b0;
			sync1 <= 1'b0;
		end else begin
			sync0 <= noisy;
			sync1 <= sync0;
		end
	end

	//----------------------------------------------------------------------
	// debounce and edge pulses
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			conditioned <= 1'b0;
			cnt <= '0;
			pos_edge <= 1'b0;
			neg_edge <= 1'b0;
		end else begin
			pos_edge <= 1'b0; // pulses default low
			neg_edge <= 1'b0;
			if (sync1 == conditioned) begin
				cnt <= '0; // glitch gone or nothing new
			end else if (cnt == cnt_w'(cond_wait - 1)) begin
				conditioned <= sync1; // held long enough, commit
				cnt <= '0;
				pos_edge <= sync1;
				neg_edge <= ~sync1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// an edge only after the new level sat in sync1 for cond_wait samples
	a_edge_debounced: assert property (@(posedge clk) disable iff (reset)
		(pos_edge || neg_edge) |-> ($past(sync1, cond_wait) == conditioned));

endmodule

// ==== hw/shift_register.sv ====
`timescale 1ns/10ps

module shift_register (
	input  logic               clk,
	input  logic               reset,
	input  logic               shift_en,  // sclk rising pulse
	input  logic               serial_in, // conditioned mosi
	input  logic               load_en,   // parallel load strobe
	input  spi_mem_pkg::data_t load_data, // memory read data
	output spi_mem_pkg::data_t q          // parallel out, q[7] feeds miso
);
	import spi_mem_pkg::*;

	data_t q_next;

	//----------------------------------------------------------------------
	// load beats shift
	//----------------------------------------------------------------------
	always_comb begin
		q_next = q;
		if (load_en) begin
			q_next = load_data;
		end else if (shift_en) begin
			q_next = {q[data_w-2:0], serial_in}; // msb first, new bit at 0
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
		end else begin
			q <= q_next;
		end
	end

	// sclk only rises well after a load in a real transfer
	a_load_alone: assert property (@(posedge clk) disable iff (reset)
		load_en |-> !shift_en);

endmodule

// ==== hw/spi_fsm.sv ====
`timescale 1ns/10ps

module spi_fsm (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      clk_edge, // sclk rising pulse
	input  logic                      abort,    // conditioned cs, high = idle
	input  logic                      rw,       // rd bit of the command
	output spi_mem_pkg::spi_strobes_t strobes
);
	import spi_mem_pkg::*;

	spi_state_t state;
	logic [3:0] bit_cnt; // sclk rises seen in the current byte

	//----------------------------------------------------------------------
	// strobes straight from the state
	//----------------------------------------------------------------------
	always_comb begin
		strobes.addr_we   = (state == st_got);
		strobes.dm_we     = (state == st_write1);
		strobes.sr_we     = (state == st_read1);
		strobes.miso_buff = (state == st_read2);
	end

	//----------------------------------------------------------------------
	// state register
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || abort) begin
			state <= st_get; // cs high drops any transfer
			bit_cnt <= '0;
		end else begin
			case (state)
				st_get: begin
					if (clk_edge) begin
						if (bit_cnt == 4'd7) begin
							state <= st_got; // command byte complete
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				st_got: begin
					// one cycle, address latched here
					bit_cnt <= '0;
					if (rw) begin
						state <= st_read0;
					end else begin
						state <= st_write0;
					end
				end
				st_read0: begin
					state <= st_read1; // memory read settles
				end
				st_read1: begin
					state <= st_read2; // shifter loads read data
				end
				st_read2: begin
					// host clocks the byte out
					if (clk_edge) begin
						if (bit_cnt == 4'd7) begin
							state <= st_done;
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				st_write0: begin
					if (clk_edge) begin
						if (bit_cnt == 4'd7) begin
							state <= st_write1; // data byte complete
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				st_write1: begin
					state <= st_done; // memory takes the byte this cycle
				end
				st_done: begin
					state <= st_done; // wait here for cs to rise
					bit_cnt <= '0;
				end
			endcase
		end
	end

	//----------------------------------------------------------------------
	// checks
	//----------------------------------------------------------------------
	// a rise in the branch cycle would never be counted
	a_branch_no_rise: assert property (@(posedge clk) disable iff (reset)
		strobes.addr_we |-> !clk_edge);

	// host raises cs only after the write cycle has passed
	a_no_write_abort: assert property (@(posedge clk) disable iff (reset)
		abort |-> !strobes.dm_we);

endmodule

// ==== hw/data_memory.sv ====
`timescale 1ns/10ps

module data_memory (
	input  logic               clk,
	input  logic               we,    // write strobe from fsm
	input  spi_mem_pkg::addr_t addr,  // latched address
	input  spi_mem_pkg::data_t wdata, // shifter contents
	output spi_mem_pkg::data_t rdata
);
	import spi_mem_pkg::*;

	data_t mem [mem_depth]; // contents undefined until written

	// synchronous write
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	assign rdata = mem[addr]; // combinational read, ready in st_read0

endmodule

// ==== hw/spi_memory.sv ====
`timescale 1ns/10ps

module spi_memory (
	input  logic clk,
	input  logic reset,
	input  logic sclk,
	input  logic cs,      // active low chip select
	input  logic mosi,
	output logic miso,
	output logic miso_en  // miso valid, stands in for the tri-state enable
);
	import spi_mem_pkg::*;

	logic         cs_n;       // inverted pin so the conditioner resets to idle
	logic         cs_n_cond;
	logic         cs_level;   // conditioned cs
	logic         sclk_rise;
	logic         sclk_fall;
	logic         mosi_cond;
	spi_strobes_t strobes;
	data_t        sr_q;
	data_t        rdata;
	spi_cmd_t     cmd;
	addr_t        addr_q;     // address latch
	logic         miso_q;

	//----------------------------------------------------------------------
	// pin conditioning
	//----------------------------------------------------------------------
	assign cs_n = ~cs;

	input_conditioner u_sclk_cond (
		.clk(clk), .reset(reset), .noisy(sclk),
		.conditioned(), .pos_edge(sclk_rise), .neg_edge(sclk_fall)
	);

	input_conditioner u_cs_cond (
		.clk(clk), .reset(reset), .noisy(cs_n),
		.conditioned(cs_n_cond), .pos_edge(), .neg_edge()
	);

	input_conditioner u_mosi_cond (
		.clk(clk), .reset(reset), .noisy(mosi),
		.conditioned(mosi_cond), .pos_edge(), .neg_edge()
	);

	assign cs_level = ~cs_n_cond; // high after reset

	//----------------------------------------------------------------------
	// control and datapath
	//----------------------------------------------------------------------
	spi_fsm u_fsm (
		.clk(clk), .reset(reset), .clk_edge(sclk_rise),
		.abort(cs_level), .rw(cmd.rd), .strobes(strobes)
	);

	shift_register u_sr (
		.clk(clk), .reset(reset), .shift_en(sclk_rise), .serial_in(mosi_cond),
		.load_en(strobes.sr_we), .load_data(rdata), .q(sr_q)
	);

	assign cmd = spi_cmd_t'(sr_q); // command byte view of the shifter

	// address taken once, in st_got
	always_ff @(posedge clk) begin
		if (strobes.addr_we) begin
			addr_q <= cmd.addr;
		end
	end

	data_memory u_mem (
		.clk(clk), .we(strobes.dm_we), .addr(addr_q),
		.wdata(sr_q), .rdata(rdata)
	);

	// miso changes on sclk fall, host samples on the rise
	always_ff @(posedge clk) begin
		if (reset) begin
			miso_q <= 1'b0;
		end else if (sclk_fall) begin
			miso_q <= sr_q[data_w-1];
		end
	end

	assign miso    = miso_q;
	assign miso_en = strobes.miso_buff;

endmodule

// ==== test/spi_memory_tb.sv ====
`timescale 1ns/10ps

module spi_memory_tb;
	import spi_mem_pkg::*;

	localparam int half = 20;         // sclk half period in clk cycles
	localparam int reset_cycles = 16;

	logic clk;
	logic reset;
	logic sclk;
	logic cs;
	logic mosi;
	logic miso;
	logic miso_en;

	data_t       model [mem_depth]; // expected contents, written entries only
	logic [31:0] rng;               // xorshift state

	spi_memory uut (
		.clk(clk), .reset(reset), .sclk(sclk), .cs(cs), .mosi(mosi),
		.miso(miso), .miso_en(miso_en)
	);

	always #2 clk = ~clk; // 4 ns period

	//----------------------------------------------------------------------
	// helpers
	//----------------------------------------------------------------------
	// advance n clk cycles, land 1 ns past the edge
	task automatic step(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "read data mismatch in %s", name);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error %s: expected %b, actual %b", name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "miso_en mismatch in %s", name);
		end
	endtask

	// poll miso_en, give up after limit cycles
	task automatic wait_miso_en(input string name, input logic level, input int limit);
		int n;
		n = 0;
		while (miso_en !== level && n < limit) begin
			step(1);
			n++;
		end
		if (miso_en !== level) begin
			$display("%s: miso_en never reached %b within %0d clk cycles", name, level, limit);
			$display("** FAIL **");
			$fatal(1, "timeout in %s", name);
		end
	endtask

	//----------------------------------------------------------------------
	// bit-banged SPI host, mode 0
	//----------------------------------------------------------------------
	task automatic shift_bits(input string name, input data_t tx, input int nbits,
			input logic en_exp, output data_t rx);
		rx = '0;
		for (int i = 0; i < nbits; i++) begin
			mosi = tx[data_w-1-i]; // set up while sclk low
			step(half);
			rx[data_w-1-i] = miso; // sample just before the rise
			check_bit(name, en_exp, miso_en);
			sclk = 1'b1;
			step(half);
			sclk = 1'b0;
		end
	endtask

	task automatic start_transfer();
		cs = 1'b0;
		step(half); // cs settles through its conditioner
	endtask

	task automatic end_transfer(input string name);
		step(half);
		cs = 1'b1;
		mosi = 1'b0;
		step(half);
		check_bit(name, 1'b0, miso_en); // idle again after cs
	endtask

	task automatic spi_write_byte(input string name, input addr_t addr, input data_t data);
		spi_cmd_t cmd;
		data_t rx;
		cmd.addr = addr;
		cmd.rd = 1'b0;
		start_transfer();
		shift_bits(name, data_t'(cmd), 8, 1'b0, rx);
		shift_bits(name, data, 8, 1'b0, rx);
		end_transfer(name);
		model[addr] = data; // later writes win
	endtask

	task automatic spi_read_byte(input string name, input addr_t addr, output data_t data);
		spi_cmd_t cmd;
		data_t rx;
		cmd.addr = addr;
		cmd.rd = 1'b1;
		start_transfer();
		shift_bits(name, data_t'(cmd), 8, 1'b0, rx); // miso_en low through command
		wait_miso_en(name, 1'b1, half);
		shift_bits(name, 8'h00, 8, 1'b1, data);
		end_transfer(name);
	endtask

	//----------------------------------------------------------------------
	// directed tests
	//----------------------------------------------------------------------
	task automatic write_then_read();
		data_t rd;
		spi_write_byte("write_then_read", 7'd5, 8'ha7);
		spi_read_byte("write_then_read", 7'd5, rd);
		check_data("write_then_read", 8'ha7, rd);
	endtask

	task automatic random_fill();
		addr_t addrs [32];
		data_t rd;
		for (int i = 0; i < 32; i++) begin
			rng = xorshift(rng);
			addrs[i] = rng[6:0];
			rng = xorshift(rng);
			spi_write_byte("random_fill", addrs[i], rng[7:0]);
		end
		for (int i = 0; i < 32; i++) begin
			spi_read_byte("random_fill", addrs[i], rd);
			check_data("random_fill", model[addrs[i]], rd);
		end
	endtask

	// cs rises mid data byte, memory must keep the old byte
	task automatic abort_write();
		spi_cmd_t cmd;
		data_t rx;
		data_t rd;
		spi_write_byte("abort_write", 7'h2a, 8'h3c);
		cmd.addr = 7'h2a;
		cmd.rd = 1'b0;
		start_transfer();
		shift_bits("abort_write", data_t'(cmd), 8, 1'b0, rx);
		shift_bits("abort_write", 8'hc3, 4, 1'b0, rx); // half a byte only
		end_transfer("abort_write");
		spi_read_byte("abort_write", 7'h2a, rd);
		check_data("abort_write", 8'h3c, rd);
	endtask

	task automatic miso_enable();
		data_t rd;
		check_bit("miso_enable", 1'b0, miso_en); // idle between transfers
		spi_read_byte("miso_enable", 7'd5, rd); // per-bit checks live in the host tasks
		check_data("miso_enable", model[5], rd);
	endtask

	// 2 cycle sclk spike, shorter than sync plus debounce
	task automatic glitch_filter();
		spi_cmd_t cmd;
		data_t rx;
		data_t rd;
		cmd.addr = 7'h11;
		cmd.rd = 1'b0;
		start_transfer();
		shift_bits("glitch_filter", data_t'(cmd), 8, 1'b0, rx);
		step(8);
		sclk = 1'b1;
		step(2);
		sclk = 1'b0;
		step(half);
		shift_bits("glitch_filter", 8'h96, 8, 1'b0, rx);
		end_transfer("glitch_filter");
		model[7'h11] = 8'h96;
		spi_read_byte("glitch_filter", 7'h11, rd);
		check_data("glitch_filter", 8'h96, rd);
	endtask

	//----------------------------------------------------------------------
	// main sequence
	//----------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		reset = 1'b1;
		sclk = 1'b0;
		cs = 1'b1; // deselected
		mosi = 1'b0;
		rng = 32'd97100;
		step(reset_cycles);
		reset = 1'b0;
		step(half);
		check_bit("reset", 1'b0, miso_en);

		write_then_read();
		random_fill();
		abort_write();
		miso_enable();
		glitch_filter();

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== spi_memory.f ====
hw/spi_mem_pkg.sv
hw/input_conditioner.sv
hw/shift_register.sv
hw/spi_fsm.sv
hw/data_memory.sv
hw/spi_memory.sv
test/spi_memory_tb.sv

// ==== Makefile ====
# Verilator build and run for the SPI memory testbench

VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT      := --lint-only -Wall --timing
TOP       := spi_memory_tb
FILELIST  := spi_memory.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass or fail comes from the log, not from the simulator's exit code
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
